// ==== Bender.yml ====
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/dcache_if.sv
  - hdl/dcache_tag_array.sv
  - hdl/dcache_ctrl.sv
  - hdl/dcache_burst.sv
  - hdl/dcache_data_array.sv
  - hdl/dcache_top.sv
  - target: simulation
    files:
      - sim/tb_dcache.sv

// ==== hdl/dcache_burst.sv ====
// dcache burst engine
// four-beat line transfer to or from memory, one word per mem_ack_i

`timescale 1ns/1ps

module dcache_burst import dcache_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  dcache_burst_if.burst   bu,
  dcache_line_if.burst    ln,
  output logic            mem_req_o,
  output logic            mem_we_o,
  output logic [XLEN-1:0] mem_adr_o,
  output logic [XLEN-1:0] mem_wdata_o,
  input  logic [XLEN-1:0] mem_rdata_i,
  input  logic            mem_ack_i
);

  adr_u                 line_q;     // line base of this burst
  logic                 we_q;
  logic [WORD_BITS-1:0] beat_q;
  logic                 done_q;
  logic                 last_beat;

  assign last_beat = mem_req_o & mem_ack_i & (beat_q == WORD_BITS'(LINE_WORDS - 1));

  // ----------------------------------------
  // beat counter
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      mem_req_o <= 1'b0;
      beat_q    <= '0;
      done_q    <= 1'b0;
    end
    else
    begin
      done_q <= last_beat;                // one cycle after 4th ack
      if (bu.start)
      begin
        mem_req_o <= 1'b1;
        beat_q    <= '0;
      end
      else if (mem_req_o && mem_ack_i)
      begin
        beat_q <= beat_q + 1'b1;
        if (last_beat)
          mem_req_o <= 1'b0;
      end
    end
  end

  // latched for the whole burst
  always_ff @(posedge clk_i)
  begin
    if (bu.start)
    begin
      line_q <= bu.line_adr;
      we_q   <= bu.we;
    end
  end

  // ----------------------------------------
  // memory and line side
  // ----------------------------------------
  assign mem_we_o    = we_q;
  assign mem_adr_o   = line_q.word;
  assign mem_wdata_o = ln.line_rdata;      // write-back word of this beat
  assign bu.done     = done_q;

  assign ln.line_idx   = line_q.f.idx;
  assign ln.word_sel   = beat_q;           // ascending word order
  assign ln.fill_we    = mem_req_o & ~we_q & mem_ack_i;
  assign ln.fill_wdata = mem_rdata_i;

  // memory only answers an open burst
  a_ack_in_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_ack_i |-> mem_req_o);

endmodule

// ==== hdl/dcache_ctrl.sv ====
// dcache controller
// registers the host request and sequences hit, write-back, fill,
// retry and flush

`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  logic            we_i,
  input  logic            flush_i,
  input  size_e           size_i,
  input  logic [XLEN-1:0] adr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic            ack_o,
  output logic            flush_done_o,
  dcache_lookup_if.ctrl   lk,
  dcache_burst_if.ctrl    bu,
  output logic            wr_en_o,
  output logic [3:0]      wr_be_o,
  output adr_u            req_adr_o,
  output logic [XLEN-1:0] req_wdata_o
);

  typedef enum logic [2:0] {
    IDLE, LOOKUP, WRITEBACK, FILL, REFILL_DONE, FLUSH_SCAN, FLUSH_WB
  } state_e;

  state_e              state_q;
  state_e              state_d;
  adr_u                in_adr;
  logic [3:0]          be;
  adr_u                req_adr_q;
  logic                req_we_q;
  logic [3:0]          req_be_q;
  logic [XLEN-1:0]     req_wdata_q;
  logic [IDX_BITS-1:0] flush_idx_q;
  adr_u                fill_adr;
  adr_u                wb_adr;
  adr_u                flush_adr;

  // ----------------------------------------
  // request register
  // ----------------------------------------
  assign in_adr.word = adr_i;

  // write data sits in its byte lanes already
  always_comb
  begin
    case (size_i)
      BYTE:    be = 4'b0001 << in_adr.f.byt;
      HALF:    be = 4'b0011 << in_adr.f.byt;
      default: be = 4'b1111;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (req_i)
    begin
      req_adr_q   <= in_adr;
      req_we_q    <= we_i;
      req_be_q    <= be;
      req_wdata_q <= wdata_i;
    end
  end

  // held through the write-back of one flushed set
  always_ff @(posedge clk_i)
    if (state_q == FLUSH_SCAN && lk.any_dirty)
      flush_idx_q <= lk.first_dirty_idx;

  // line base addresses, offsets zeroed
  always_comb
  begin
    fill_adr.word  = {req_adr_q.f.tag, req_adr_q.f.idx, {(WORD_BITS + BYTE_BITS){1'b0}}};
    wb_adr.word    = {lk.victim_tag, req_adr_q.f.idx, {(WORD_BITS + BYTE_BITS){1'b0}}};
    flush_adr.word = {lk.victim_tag, lk.first_dirty_idx, {(WORD_BITS + BYTE_BITS){1'b0}}};
  end

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      state_q <= IDLE;
    else
      state_q <= state_d;

  always_comb
  begin
    state_d      = state_q;
    bu.start     = 1'b0;
    bu.we        = 1'b0;
    bu.line_adr  = fill_adr;
    lk.tag_we    = 1'b0;
    lk.dirty_clr = 1'b0;
    case (state_q)
      IDLE:
      begin
        if (flush_i)
          state_d = FLUSH_SCAN;
        else if (req_i)
          state_d = LOOKUP;
      end
      LOOKUP:                             // decision cycle
      begin
        if (lk.hit)
          state_d = IDLE;
        else if (lk.victim_dirty)
        begin
          bu.start    = 1'b1;             // evict first
          bu.we       = 1'b1;
          bu.line_adr = wb_adr;
          state_d     = WRITEBACK;
        end
        else
        begin
          bu.start = 1'b1;                // clean victim, fill directly
          state_d  = FILL;
        end
      end
      WRITEBACK:
      begin
        if (bu.done)
        begin
          lk.dirty_clr = 1'b1;
          bu.start     = 1'b1;            // fill right behind it
          state_d      = FILL;
        end
      end
      FILL:
      begin
        if (bu.done)
        begin
          lk.tag_we = 1'b1;
          state_d   = REFILL_DONE;
        end
      end
      REFILL_DONE: state_d = LOOKUP;      // retry, hits now
      FLUSH_SCAN:
      begin
        if (lk.any_dirty)
        begin
          bu.start    = 1'b1;
          bu.we       = 1'b1;
          bu.line_adr = flush_adr;
          state_d     = FLUSH_WB;
        end
        else
          state_d = IDLE;
      end
      FLUSH_WB:
      begin
        if (bu.done)
        begin
          lk.dirty_clr = 1'b1;
          state_d      = FLUSH_SCAN;      // look for the next one
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  assign ack_o        = (state_q == LOOKUP) & lk.hit;
  assign wr_en_o      = ack_o & req_we_q;          // write hit
  assign flush_done_o = (state_q == FLUSH_SCAN) & ~lk.any_dirty;

  assign lk.adr       = req_adr_q;
  assign lk.dirty_set = wr_en_o;
  assign lk.flush     = (state_q == FLUSH_SCAN) || (state_q == FLUSH_WB);
  assign lk.flush_idx = (state_q == FLUSH_SCAN) ? lk.first_dirty_idx : flush_idx_q;

  assign wr_be_o     = req_be_q;
  assign req_adr_o   = req_adr_q;
  assign req_wdata_o = req_wdata_q;

  // one request or flush at a time
  a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i || flush_i) |-> state_q == IDLE);

  // next burst only once the current one reports done
  a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bu.start |=> (!bu.start until bu.done));

endmodule

// ==== hdl/dcache_data_array.sv ====
// dcache data array
// line storage in flops, byte-enable merge for host writes,
// whole words from fills, combinational word select on both sides

`timescale 1ns/1ps

module dcache_data_array import dcache_pkg::*; (
  input  logic            clk_i,
  dcache_line_if.data     ln,
  input  logic            wr_en_i,
  input  logic [3:0]      wr_be_i,
  input  adr_u            req_adr_i,
  input  logic [XLEN-1:0] req_wdata_i,
  output logic [XLEN-1:0] rdata_o
);

  logic [LINE_BITS-1:0] lines_q [SETS];
  logic [XLEN-1:0]      host_word;   // addressed word, current content
  logic [XLEN-1:0]      merged;      // host_word with written bytes replaced

  // ----------------------------------------
  // read
  // ----------------------------------------
  assign host_word     = lines_q[req_adr_i.f.idx][req_adr_i.f.wrd * XLEN +: XLEN];
  assign rdata_o       = host_word;
  assign ln.line_rdata = lines_q[ln.line_idx][ln.word_sel * XLEN +: XLEN];  // write-back

  // ----------------------------------------
  // byte merge
  // ----------------------------------------
  always_comb
  begin
    merged = host_word;
    for (int b = 0; b < XLEN / 8; b++)
      if (wr_be_i[b])
        merged[b * 8 +: 8] = req_wdata_i[b * 8 +: 8];
  end

  // ----------------------------------------
  // write
  // ----------------------------------------
  // fill and host write never overlap, fill checked first anyway
  always_ff @(posedge clk_i)
  begin
    if (ln.fill_we)
      lines_q[ln.line_idx][ln.word_sel * XLEN +: XLEN] <= ln.fill_wdata;
    else if (wr_en_i)
      lines_q[req_adr_i.f.idx][req_adr_i.f.wrd * XLEN +: XLEN] <= merged;
  end

endmodule

// ==== hdl/dcache_if.sv ====
// dcache internal interfaces
// lookup between controller and tag array, burst between controller and
// burst engine, line between burst engine and data array

`timescale 1ns/1ps

interface dcache_lookup_if import dcache_pkg::*; ();
  adr_u                adr;              // registered request address
  logic                flush;            // select flush_idx instead of adr index
  logic [IDX_BITS-1:0] flush_idx;        // set under flush
  logic                tag_we;           // set becomes valid, clean, tagged
  logic                dirty_set;        // host write hit
  logic                dirty_clr;        // line written back
  logic                hit;
  logic                victim_dirty;
  logic [TAG_BITS-1:0] victim_tag;
  logic                any_dirty;
  logic [IDX_BITS-1:0] first_dirty_idx;  // lowest dirty set

  modport ctrl (output adr, flush, flush_idx, tag_we, dirty_set, dirty_clr,
                input  hit, victim_dirty, victim_tag, any_dirty, first_dirty_idx);
  modport tags (input  adr, flush, flush_idx, tag_we, dirty_set, dirty_clr,
                output hit, victim_dirty, victim_tag, any_dirty, first_dirty_idx);
endinterface

interface dcache_burst_if import dcache_pkg::*; ();
  logic start;     // one cycle strobe
  logic we;        // 1 = write-back, 0 = fill
  adr_u line_adr;  // line base, offsets zero
  logic done;      // one cycle strobe after last beat

  modport ctrl  (output start, we, line_adr, input  done);
  modport burst (input  start, we, line_adr, output done);
endinterface

interface dcache_line_if import dcache_pkg::*; ();
  logic [IDX_BITS-1:0]  line_idx;
  logic [WORD_BITS-1:0] word_sel;   // current beat
  logic                 fill_we;
  logic [XLEN-1:0]      fill_wdata;
  logic [XLEN-1:0]      line_rdata; // word_sel of line_idx

  modport burst (output line_idx, word_sel, fill_we, fill_wdata, input  line_rdata);
  modport data  (input  line_idx, word_sel, fill_we, fill_wdata, output line_rdata);
endinterface

// ==== hdl/dcache_pkg.sv ====
// dcache shared definitions
// cache geometry, host access size and the two views of an address word

package dcache_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------
  localparam int XLEN       = 32;               // data word width
  localparam int LINE_WORDS = 4;                // words per line = beats per burst
  localparam int SETS       = 16;               // direct mapped, one line per set
  localparam int BYTE_BITS  = 2;                // byte in word
  localparam int WORD_BITS  = 2;                // word in line
  localparam int IDX_BITS   = 4;                // set index
  localparam int TAG_BITS   = XLEN - IDX_BITS - WORD_BITS - BYTE_BITS;  // 24
  localparam int LINE_BITS  = LINE_WORDS * XLEN;                        // 128

  // ----------------------------------------
  // host access size
  // ----------------------------------------
  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } size_e;

  // ----------------------------------------
  // address word
  // ----------------------------------------
  // field split of a byte address, msb first
  typedef struct packed {
    logic [TAG_BITS-1:0]  tag;
    logic [IDX_BITS-1:0]  idx;
    logic [WORD_BITS-1:0] wrd;
    logic [BYTE_BITS-1:0] byt;
  } adr_fields_s;

  // same 32 bits, either as a flat address or split into fields
  typedef union packed {
    logic [XLEN-1:0] word;   // flat byte address
    adr_fields_s     f;      // tag / index / word / byte
  } adr_u;

endpackage

// ==== hdl/dcache_tag_array.sv ====
// dcache tag array
// per-set valid/dirty/tag in flops, hit and victim decode for the
// selected set, lowest dirty set for flush

`timescale 1ns/1ps

module dcache_tag_array import dcache_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  dcache_lookup_if.tags lk
);

  logic [SETS-1:0]     valid_q;
  logic [SETS-1:0]     dirty_q;
  logic [TAG_BITS-1:0] tag_q [SETS];
  logic [IDX_BITS-1:0] set;        // set being looked at / written

  // flush walks sets by index, otherwise request index
  assign set = lk.flush ? lk.flush_idx : lk.adr.f.idx;

  // ----------------------------------------
  // decode
  // ----------------------------------------
  assign lk.hit          = valid_q[set] & (tag_q[set] == lk.adr.f.tag);
  assign lk.victim_dirty = valid_q[set] & dirty_q[set];
  assign lk.victim_tag   = tag_q[set];
  assign lk.any_dirty    = |dirty_q;

  // scan down so the lowest dirty set wins
  always_comb
  begin
    lk.first_dirty_idx = '0;
    for (int s = SETS - 1; s >= 0; s--)
      if (dirty_q[s])
        lk.first_dirty_idx = IDX_BITS'(s);
  end

  // ----------------------------------------
  // update
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else if (lk.tag_we)
    begin
      valid_q[set] <= 1'b1;   // fresh line, clean
      dirty_q[set] <= 1'b0;
    end
    else if (lk.dirty_set)
      dirty_q[set] <= 1'b1;
    else if (lk.dirty_clr)
      dirty_q[set] <= 1'b0;   // after write-back
  end

  always_ff @(posedge clk_i)
    if (lk.tag_we)
      tag_q[set] <= lk.adr.f.tag;

  // fill completion and write-back completion are separate states
  a_tag_we_dirty_clr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(lk.tag_we && lk.dirty_clr));

endmodule

// ==== hdl/dcache_top.sv ====
// dcache top level
// direct-mapped write-back data cache with host port, flush and memory burst port

`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  // host
  input  logic            req_i,
  input  logic            we_i,
  input  size_e           size_i,
  input  logic [XLEN-1:0] adr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic [XLEN-1:0] rdata_o,
  output logic            ack_o,
  input  logic            flush_i,
  output logic            flush_done_o,
  // memory
  output logic            mem_req_o,
  output logic            mem_we_o,
  output logic [XLEN-1:0] mem_adr_o,
  output logic [XLEN-1:0] mem_wdata_o,
  input  logic [XLEN-1:0] mem_rdata_i,
  input  logic            mem_ack_i
);

  dcache_lookup_if lk_if ();
  dcache_burst_if  bu_if ();
  dcache_line_if   ln_if ();

  logic            wr_en;
  logic [3:0]      wr_be;
  adr_u            req_adr;
  logic [XLEN-1:0] req_wdata;

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  dcache_tag_array u_tags (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .lk     (lk_if.tags)
  );

  // ----------------------------------------
  // control and burst
  // ----------------------------------------
  dcache_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .we_i         (we_i),
    .flush_i      (flush_i),
    .size_i       (size_i),
    .adr_i        (adr_i),
    .wdata_i      (wdata_i),
    .ack_o        (ack_o),
    .flush_done_o (flush_done_o),
    .lk           (lk_if.ctrl),
    .bu           (bu_if.ctrl),
    .wr_en_o      (wr_en),
    .wr_be_o      (wr_be),
    .req_adr_o    (req_adr),
    .req_wdata_o  (req_wdata)
  );

  dcache_burst u_burst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bu          (bu_if.burst),
    .ln          (ln_if.burst),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_adr_o   (mem_adr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i),
    .mem_ack_i   (mem_ack_i)
  );

  // ----------------------------------------
  // data
  // ----------------------------------------
  dcache_data_array u_data (
    .clk_i       (clk_i),
    .ln          (ln_if.data),
    .wr_en_i     (wr_en),
    .wr_be_i     (wr_be),
    .req_adr_i   (req_adr),
    .req_wdata_i (req_wdata),
    .rdata_o     (rdata_o)
  );

endmodule

// ==== sim/tb_dcache.sv ====
// dcache testbench
// random-latency burst memory, shadow memory and a direct-mapped cache
// model; directed and random traffic, checked by concurrent assertions

`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int MEM_WORDS  = 1024;                   // 4 KiB behind the cache
  localparam int MEM_AW     = $clog2(MEM_WORDS);
  localparam int MAX_WAIT   = 3;                      // wait cycles per beat
  localparam int N_RANDOM   = 24;
  localparam int N_REQ      = 16 + N_RANDOM + 2 * SETS;  // a flush counts one wb per set
  localparam int MISS_CYC   = 2 * (LINE_WORDS * (MAX_WAIT + 1) + 2) + 4;  // wb + fill

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic            req_i;
  logic            we_i;
  size_e           size_i;
  logic [XLEN-1:0] adr_i;
  logic [XLEN-1:0] wdata_i;
  logic [XLEN-1:0] rdata_o;
  logic            ack_o;
  logic            flush_i;
  logic            flush_done_o;
  logic            mem_req_o;
  logic            mem_we_o;
  logic [XLEN-1:0] mem_adr_o;
  logic [XLEN-1:0] mem_wdata_o;
  logic [XLEN-1:0] mem_rdata_i;
  logic            mem_ack_i;

  logic [XLEN-1:0]     mem     [MEM_WORDS];  // memory model content
  logic [XLEN-1:0]     shadow  [MEM_WORDS];  // what memory should hold
  logic                written [MEM_WORDS];
  logic                mdl_valid [SETS];     // expected cache state
  logic                mdl_dirty [SETS];
  logic [TAG_BITS-1:0] mdl_tag   [SETS];
  logic                exp_hit;
  int                  exp_wb;               // write-backs before the fill
  logic [XLEN-1:0]     exp_rdata;
  logic                cur_we;
  logic                seen_req;
  logic                in_burst;
  int                  mem_beat;             // acks given in this burst
  int                  ack_beat;             // word of the ack on the bus
  int                  wb_bursts;
  int                  errors = 0;
  int                  tests = 0;
  int                  failed = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  dcache_top uut (.*);

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic int widx(input logic [XLEN-1:0] a);
    return int'(a[MEM_AW+1:2]);
  endfunction

  function automatic logic [XLEN-1:0] init_word(input logic [XLEN-1:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};  // every address bit counts
  endfunction

  function automatic logic [XLEN-1:0] shadow_at(input logic [XLEN-1:0] a);
    return shadow[widx(a)];
  endfunction

  function automatic int first_mismatch();
    for (int i = 0; i < MEM_WORDS; i++)
      if (written[i] && mem[i] !== shadow[i])
        return i;
    return -1;
  endfunction

  // lanes covered by an access of n bytes starting at off
  function automatic logic [3:0] lane_mask(input size_e sz, input logic [1:0] off);
    int n;
    n = (sz == BYTE) ? 1 : (sz == HALF) ? 2 : 4;
    for (int b = 0; b < 4; b++)
      lane_mask[b] = (b >= off) && (b < off + n);
  endfunction

  // direct mapped, write-back, write-allocate
  task automatic predict(input logic [XLEN-1:0] a, input logic wr);
    adr_u u;
    u.word  = a;
    exp_hit = mdl_valid[u.f.idx] && (mdl_tag[u.f.idx] == u.f.tag);
    exp_wb  = (!exp_hit && mdl_valid[u.f.idx] && mdl_dirty[u.f.idx]) ? 1 : 0;
    if (!exp_hit)
    begin
      mdl_valid[u.f.idx] = 1'b1;
      mdl_tag[u.f.idx]   = u.f.tag;
      mdl_dirty[u.f.idx] = 1'b0;
    end
    if (wr)
      mdl_dirty[u.f.idx] = 1'b1;
  endtask

  task automatic access(input logic [XLEN-1:0] a, input logic wr, input size_e sz,
                        input logic [XLEN-1:0] wd);
    logic [3:0] m;
    int         n;
    predict(a, wr);
    m = lane_mask(sz, a[1:0]);
    for (int b = 0; b < 4; b++)
      if (wr && m[b])
        shadow[widx(a)][b*8 +: 8] = wd[b*8 +: 8];
    if (wr)
      written[widx(a)] = 1'b1;
    exp_rdata = shadow[widx(a)];
    cur_we    = wr;
    wb_bursts = 0;
    seen_req  = 1'b1;
    req_i     = 1'b1;
    we_i      = wr;
    size_i    = sz;
    adr_i     = a;
    wdata_i   = wd;
    @(posedge clk_i);
    #1 req_i = 1'b0;
    n = 0;
    while (!ack_o && n < 2 * MISS_CYC)
    begin
      @(posedge clk_i);
      #1 n++;
    end
    if (!ack_o)
    begin
      $display("no ack for the request to %h within %0d cycles", a, n);
      errors++;
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic flush_all();
    int n;
    for (int s = 0; s < SETS; s++)
      mdl_dirty[s] = 1'b0;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1 flush_i = 1'b0;
    n = 0;
    while (!flush_done_o && n < SETS * MISS_CYC)
    begin
      @(posedge clk_i);
      #1 n++;
    end
    if (!flush_done_o)
    begin
      $display("flush did not complete within %0d cycles", n);
      errors++;
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    if (errors == err_before)
      $display("test %-10s ok", name);
    else
    begin
      failed++;
      $display("test %-10s failed with %0d errors", name, errors - err_before);
    end
  endtask

  // ----------------------------------------
  // memory model
  // ----------------------------------------
  task automatic memory_model();
    int wait_cnt;
    wait_cnt = 0;
    forever
    begin
      @(posedge clk_i);
      #1 mem_ack_i = 1'b0;                 // ack lasts one cycle
      if (!mem_req_o)
        in_burst = 1'b0;
      else
      begin
        if (!in_burst)                     // new burst
        begin
          in_burst = 1'b1;
          mem_beat = 0;
          wait_cnt = $urandom_range(MAX_WAIT, 0);
          if (mem_we_o)
            wb_bursts++;
        end
        if (mem_beat < LINE_WORDS && wait_cnt > 0)
          wait_cnt--;
        else if (mem_beat < LINE_WORDS)
        begin
          ack_beat  = mem_beat;
          mem_ack_i = 1'b1;
          if (mem_we_o)
            mem[widx(mem_adr_o) + mem_beat] = mem_wdata_o;
          else
            mem_rdata_i = mem[widx(mem_adr_o) + mem_beat];
          mem_beat++;
          wait_cnt = $urandom_range(MAX_WAIT, 0);
        end
      end
    end
  endtask

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seen_req |-> (!ack_o && !flush_done_o && !mem_req_o))
    else
    begin
      $display("quiet outputs went active before the first request");
      errors++;
    end

  a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |=> (ack_o == exp_hit))          // a hit acks one cycle after req_i
    else
    begin
      $display("[ERROR] %0t ack_o expected %b got %b", $time, exp_hit, $sampled(ack_o));
      errors++;
    end

  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_o && !cur_we) |-> (rdata_o == exp_rdata))
    else
    begin
      $display("[ERROR] %0t rdata_o expected %h got %h", $time, exp_rdata,
               $sampled(rdata_o));
      errors++;
    end

  a_wb_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && mem_we_o && mem_ack_i) |->
      (mem_wdata_o == shadow_at(mem_adr_o + 4 * ack_beat)))
    else
    begin
      $display("[ERROR] %0t mem_wdata_o expected %h got %h", $time,
               shadow_at($sampled(mem_adr_o) + 4 * ack_beat), $sampled(mem_wdata_o));
      errors++;
    end

  a_wb_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($rose(mem_req_o) && !mem_we_o) |-> (wb_bursts == exp_wb))  // victim out before fill
    else
    begin
      $display("[ERROR] %0t wb_bursts expected %0d got %0d", $time, exp_wb, wb_bursts);
      errors++;
    end

  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(mem_req_o) |-> (mem_beat == LINE_WORDS))
    else
    begin
      $display("[ERROR] %0t mem_req_o beats expected %0d got %0d", $time, LINE_WORDS,
               mem_beat);
      errors++;
    end

  a_req_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_ack_i && ack_beat == LINE_WORDS - 1) |=> !mem_req_o)
    else
    begin
      $display("[ERROR] %0t mem_req_o expected 0 got 1", $time);
      errors++;
    end

  a_flushed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_done_o |-> (first_mismatch() < 0))
    else
    begin
      $display("[ERROR] %0t mem[%h] expected %h got %h", $time, first_mismatch() * 4,
               shadow[first_mismatch()], mem[first_mismatch()]);
      errors++;
    end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial
  begin : stimulus
    int              e;
    logic [XLEN-1:0] a;
    logic            wr;
    size_e           sz;
    logic [1:0]      off;
    void'($urandom(9034));
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    size_i      = WORD;
    adr_i       = '0;
    wdata_i     = '0;
    flush_i     = 1'b0;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    exp_hit     = 1'b0;
    exp_wb      = 0;
    exp_rdata   = '0;
    cur_we      = 1'b0;
    seen_req    = 1'b0;
    in_burst    = 1'b0;
    mem_beat    = 0;
    ack_beat    = 0;
    wb_bursts   = 0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem[i]     = init_word(XLEN'(i * 4));
      shadow[i]  = mem[i];
      written[i] = 1'b0;
    end
    for (int s = 0; s < SETS; s++)
    begin
      mdl_valid[s] = 1'b0;
      mdl_dirty[s] = 1'b0;
      mdl_tag[s]   = '0;
    end
    fork
      memory_model();                      // inherits the seeded generator
    join_none
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    e = errors;                            // idle after reset
    repeat (6) @(posedge clk_i);
    #1 report("reset", e);

    e = errors;                            // miss, then hit on the same word
    access(32'h0000_0124, 1'b0, WORD, '0);
    access(32'h0000_0124, 1'b0, WORD, '0);
    report("read_hit", e);

    e = errors;                            // mixed sizes into one line
    access(32'h0000_0130, 1'b1, WORD, $urandom);
    access(32'h0000_0131, 1'b1, BYTE, $urandom);
    access(32'h0000_0136, 1'b1, HALF, $urandom);
    access(32'h0000_013b, 1'b1, BYTE, $urandom);
    access(32'h0000_0130, 1'b0, WORD, '0);
    access(32'h0000_0134, 1'b0, WORD, '0);
    access(32'h0000_0138, 1'b0, WORD, '0);
    report("byte_merge", e);

    e = errors;                            // same index, other tag
    access(32'h0000_0150, 1'b1, WORD, $urandom);
    access(32'h0000_0250, 1'b0, WORD, '0);
    access(32'h0000_0154, 1'b0, WORD, '0);
    report("writeback", e);

    e = errors;
    access(32'h0000_01c6, 1'b1, HALF, $urandom);
    access(32'h0000_03e9, 1'b1, BYTE, $urandom);
    access(32'h0000_0204, 1'b1, WORD, $urandom);
    flush_all();
    report("flush", e);

    e = errors;                            // random traffic over 2 KiB, 8 tags per set
    for (int i = 0; i < N_RANDOM; i++)
    begin
      wr  = 1'($urandom_range(1, 0));
      sz  = size_e'($urandom_range(2, 0));
      off = 2'($urandom_range(3, 0));
      if (sz == HALF)
        off[0] = 1'b0;
      else if (sz == WORD)
        off = 2'b00;
      a = XLEN'($urandom_range(511, 0)) << 2 | XLEN'(off);
      access(a, wr, sz, $urandom);
    end
    flush_all();
    report("random", e);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // run-length bound from request count and worst-case miss
  initial
  begin : watchdog
    #(N_REQ * MISS_CYC * 2 * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
hdl/dcache_pkg.sv
hdl/dcache_if.sv
hdl/dcache_tag_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_burst.sv
hdl/dcache_data_array.sv
hdl/dcache_top.sv
sim/tb_dcache.sv
